/* redundancy_ctrl.f */
logic/safety_pkg.sv
logic/mode_sequencer.sv
logic/tmr_lane_fsm.sv
logic/tmr_error_filter.sv
logic/dmr_lane_fsm.sv
logic/lane_merge.sv
logic/redundancy_ctrl.sv
sim/redundancy_ctrl_sva.sv
sim/tb_redundancy_ctrl.sv

/* sim/tb_redundancy_ctrl.sv */
// Redundancy controller testbench
// Boot, TMR start, resync, critical section, DMR recovery and end of run
`timescale 1ns/100ps

module tb_redundancy_ctrl;
  localparam int  MAX_DLY = 6;                        // Longest hart answer in cycles
  localparam int  LIMIT   = 6 * 8 * MAX_DLY + 100;    // Six scenarios plus margin
  localparam time DRV     = 10ns;

  logic                  clk_i = 1'b0;
  logic                  rst_ni, start_i, end_sw_routine_i;
  logic                  tmr_critical_section_i, tmr_error_i;
  safety_pkg::safe_cfg_t safe_cfg_i;
  safety_pkg::hart_vec_t dmr_mask_i, dmr_error_i, halt_ack_i, hart_wfi_i, hart_intc_ack_i;
  safety_pkg::hart_vec_t interrupt_halt_o, interrupt_swresync_o, dmr_config_o, wfi_dmr_o;
  logic                  single_bus_o, tmr_voter_enable_o, dmr_comparator_enable_o;
  logic                  delayed_o, start_boot_o, dmr_rec_o, en_ext_debug_req_o;
  int unsigned           cycles = 0;

  redundancy_ctrl UUT (.*);

  always #50 clk_i = ~clk_i;

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #DRV;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Hart responder model
  ////////////////////////////////////////////////////////////////////////////
  task automatic answer_halt(input int idx);
    forever begin
      skip_cycles(1);
      if (interrupt_halt_o[idx]) begin
        skip_cycles($urandom_range(MAX_DLY, 1));
        halt_ack_i[idx] = 1'b1;
        while (interrupt_halt_o[idx]) skip_cycles(1);
        skip_cycles($urandom_range(MAX_DLY, 1));
        halt_ack_i[idx] = 1'b0;
      end
    end
  endtask

  task automatic answer_resync(input int idx);
    forever begin
      skip_cycles(1);
      if (interrupt_swresync_o[idx]) begin
        skip_cycles($urandom_range(MAX_DLY, 1));
        hart_intc_ack_i[idx] = 1'b1;
        do begin
          @(posedge clk_i);
        end while (hart_intc_ack_i != '1);  // All harts joined
        skip_cycles($urandom_range(MAX_DLY, 1));
        hart_intc_ack_i[idx] = 1'b0;
        while (interrupt_swresync_o[idx]) skip_cycles(1);
      end
    end
  endtask

  task automatic wait_resync_done();
    while (interrupt_swresync_o != '1) skip_cycles(1);
    while (|interrupt_swresync_o) skip_cycles(1);
  endtask

  task automatic wait_boot_done();
    while (!start_boot_o) skip_cycles(1);
    while (start_boot_o) skip_cycles(1);
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("Run did not finish within %0d cycles", LIMIT);
      $display("Test FAILED");
      $fatal(1, "Timeout");
    end else if (UUT.u_sva.fail_count != 0) begin
      $display("Test FAILED");
      $fatal(1, "A checker assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'haa04_184a));
    rst_ni                 = 1'b0;
    safe_cfg_i             = safety_pkg::CFG_SINGLE;
    start_i                = 1'b0;
    end_sw_routine_i       = 1'b0;
    dmr_mask_i             = '0;
    tmr_critical_section_i = 1'b0;
    tmr_error_i            = 1'b0;
    dmr_error_i            = '0;
    halt_ack_i             = '0;
    hart_wfi_i             = '0;
    hart_intc_ack_i        = '0;
    fork
      answer_halt(0);
      answer_halt(1);
      answer_halt(2);
      answer_resync(0);
      answer_resync(1);
      answer_resync(2);
    join_none
    skip_cycles(8);
    rst_ni = 1'b1;

    skip_cycles(6);  // Boot code running
    hart_wfi_i = '1;
    while (!en_ext_debug_req_o) skip_cycles(1);

    // TMR start, then a resync outside the critical section
    hart_wfi_i = '0;
    safe_cfg_i = safety_pkg::CFG_TMR;
    start_i    = 1'b1;
    wait_boot_done();
    tmr_error_i = 1'b1;
    skip_cycles(1);
    tmr_error_i = 1'b0;
    wait_resync_done();

    // Critical section, only the second error counts
    tmr_critical_section_i = 1'b1;
    skip_cycles(2);
    tmr_error_i = 1'b1;
    skip_cycles(1);
    tmr_error_i = 1'b0;
    skip_cycles(4);
    tmr_error_i = 1'b1;
    skip_cycles(1);
    tmr_error_i = 1'b0;
    wait_resync_done();
    tmr_critical_section_i = 1'b0;

    hart_wfi_i       = '1;
    end_sw_routine_i = 1'b1;
    start_i          = 1'b0;
    while (!en_ext_debug_req_o) skip_cycles(1);
    end_sw_routine_i = 1'b0;

    // Delayed DMR on the low pair, compare error and recovery
    hart_wfi_i = '0;
    safe_cfg_i = safety_pkg::CFG_DMR_DELAYED;
    dmr_mask_i = safety_pkg::DMR_MASK_LOW;
    start_i    = 1'b1;
    wait_boot_done();
    dmr_error_i = 3'b001;
    skip_cycles(1);
    dmr_error_i = '0;
    while (wfi_dmr_o != safety_pkg::DMR_MASK_LOW) skip_cycles(1);
    hart_wfi_i = '1;
    while (!dmr_rec_o) skip_cycles(1);
    while (dmr_rec_o) skip_cycles(1);

    end_sw_routine_i = 1'b1;
    start_i          = 1'b0;
    while (!en_ext_debug_req_o) skip_cycles(1);
    end_sw_routine_i = 1'b0;
    skip_cycles(2);
    safe_cfg_i = safety_pkg::CFG_SINGLE;  // Parked in single config clears delayed
    while (delayed_o) skip_cycles(1);
    skip_cycles(2);

    if (UUT.u_sva.fail_count != 0) begin
      $display("Test FAILED");
      $fatal(1, "Checker reported failures");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* sim/redundancy_ctrl_sva.sv */
// Redundancy controller checker
// Concurrent checks on boot, halt and resync handshakes, DMR recovery and the end
`timescale 1ns/100ps

module redundancy_ctrl_sva (
  input logic                  clk_i,
  input logic                  rst_ni,
  input safety_pkg::safe_cfg_t safe_cfg_i,
  input logic                  start_i, end_sw_routine_i, tmr_critical_section_i, tmr_error_i,
  input safety_pkg::hart_vec_t dmr_mask_i, dmr_error_i, halt_ack_i, hart_wfi_i,
  input safety_pkg::hart_vec_t hart_intc_ack_i, tmr_in_sync_i,
  input safety_pkg::hart_vec_t interrupt_halt_o, interrupt_swresync_o, dmr_config_o, wfi_dmr_o,
  input logic                  single_bus_o, tmr_voter_enable_o, dmr_comparator_enable_o,
  input logic                  delayed_o, start_boot_o, dmr_rec_o, en_ext_debug_req_o
);
  logic        armed_q;     // Sequencer has left its reset state
  logic        booted_q;
  logic        err_prev_q;
  logic        acked_q;     // Every intc ack rose in the current resync
  logic [1:0]  cs_errs_q;   // Error pulses in the current critical section
  int unsigned fail_count = 0;

  function automatic void record_error(input string msg);
    $error("%s", msg);
    fail_count++;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q    <= 1'b0;
      booted_q   <= 1'b0;
      err_prev_q <= 1'b0;
      acked_q    <= 1'b0;
      cs_errs_q  <= '0;
    end else begin
      armed_q    <= 1'b1;
      err_prev_q <= tmr_error_i;
      if (armed_q && &hart_wfi_i) booted_q <= 1'b1;
      if (interrupt_swresync_o == '0) begin
        acked_q <= 1'b0;
      end else if (&hart_intc_ack_i) begin
        acked_q <= 1'b1;
      end
      if (!tmr_critical_section_i) begin
        cs_errs_q <= '0;
      end else if (&tmr_in_sync_i && tmr_error_i && !err_prev_q) begin
        cs_errs_q <= cs_errs_q + 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Boot and TMR start
  ////////////////////////////////////////////////////////////////////////////
  a_boot: assert property (@(posedge clk_i) disable iff (!rst_ni) armed_q && !booted_q |->
      single_bus_o && tmr_voter_enable_o && !en_ext_debug_req_o)
    else record_error($sformatf("** Error boot: expected bus voter debug 110, got %b%b%b",
                                single_bus_o, tmr_voter_enable_o, en_ext_debug_req_o));
  a_boot_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni) armed_q && !booted_q |->
      interrupt_halt_o == '0 && interrupt_swresync_o == '0 && wfi_dmr_o == '0 &&
      !start_boot_o && !dmr_rec_o && !delayed_o && !dmr_comparator_enable_o)
    else record_error($sformatf("** Error boot_quiet: expected 000 000 000 0000, got %b %b %b %b",
                                interrupt_halt_o, interrupt_swresync_o, wfi_dmr_o,
                                {start_boot_o, dmr_rec_o, delayed_o, dmr_comparator_enable_o}));
  a_boot_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      armed_q && !booted_q && &hart_wfi_i |=> en_ext_debug_req_o)
    else record_error("** Error boot_exit: expected debug 1, got 0");
  a_tmr_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      en_ext_debug_req_o && start_i && safe_cfg_i == safety_pkg::CFG_TMR |->
      ##2 interrupt_halt_o == '1)
    else record_error($sformatf("** Error tmr_start: expected 111, got %b", interrupt_halt_o));
  a_halt_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ($past(interrupt_halt_o & ~halt_ack_i) & ~interrupt_halt_o) == '0)
    else record_error($sformatf("** Error halt_hold: expected 0 dropped, got %b", interrupt_halt_o));
  a_halt_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ($past(halt_ack_i) & interrupt_halt_o) == '0)  // Low while the ack is still up
    else record_error($sformatf("** Error halt_release: expected 000, got %b", interrupt_halt_o));
  a_boot_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
      |interrupt_halt_o && !dmr_rec_o |-> start_boot_o)
    else record_error("** Error start_boot: expected 1, got 0");

  ////////////////////////////////////////////////////////////////////////////
  // TMR resync and critical section
  ////////////////////////////////////////////////////////////////////////////
  a_resync_rise: assert property (@(posedge clk_i) disable iff (!rst_ni) &tmr_in_sync_i &&
      tmr_error_i && !tmr_critical_section_i && !end_sw_routine_i |=> interrupt_swresync_o == '1)
    else record_error($sformatf("** Error resync: expected 111, got %b", interrupt_swresync_o));
  a_resync_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      interrupt_swresync_o == '1 && (!acked_q || hart_intc_ack_i != '0) |=>
      interrupt_swresync_o == '1)
    else record_error($sformatf("** Error resync_hold: expected 111, got %b", interrupt_swresync_o));
  a_resync_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
      interrupt_swresync_o == '1 && acked_q && hart_intc_ack_i == '0 |=>
      interrupt_swresync_o == '0)
    else record_error($sformatf("** Error resync_drop: expected 000, got %b", interrupt_swresync_o));
  a_voter: assert property (@(posedge clk_i) disable iff (!rst_ni)
      |interrupt_swresync_o |-> tmr_voter_enable_o)
    else record_error("** Error voter: expected 1, got 0");
  a_cs_first: assert property (@(posedge clk_i) disable iff (!rst_ni) tmr_critical_section_i &&
      &tmr_in_sync_i && tmr_error_i && !err_prev_q && cs_errs_q == 2'd0 |=>
      interrupt_swresync_o == '0)
    else record_error($sformatf("** Error cs_first: expected 000, got %b", interrupt_swresync_o));
  a_cs_second: assert property (@(posedge clk_i) disable iff (!rst_ni) tmr_critical_section_i &&
      &tmr_in_sync_i && tmr_error_i && !err_prev_q && cs_errs_q == 2'd1 |=>
      interrupt_swresync_o == '1)
    else record_error($sformatf("** Error cs_second: expected 111, got %b", interrupt_swresync_o));

  ////////////////////////////////////////////////////////////////////////////
  // DMR, end of run
  ////////////////////////////////////////////////////////////////////////////
  a_dmr_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      en_ext_debug_req_o && start_i && dmr_mask_i != '0 &&
      (safe_cfg_i == safety_pkg::CFG_DMR || safe_cfg_i == safety_pkg::CFG_DMR_DELAYED) |->
      ##2 dmr_config_o == dmr_mask_i && interrupt_halt_o == dmr_mask_i &&
      dmr_comparator_enable_o)
    else record_error($sformatf("** Error dmr_start: expected %b %b 1, got %b %b %b",
                                dmr_mask_i, dmr_mask_i, dmr_config_o, interrupt_halt_o,
                                dmr_comparator_enable_o));
  a_dmr_cfg: assert property (@(posedge clk_i) disable iff (!rst_ni) |dmr_config_o |->
      dmr_config_o == dmr_mask_i &&
      (safe_cfg_i != safety_pkg::CFG_DMR_DELAYED || delayed_o))
    else record_error($sformatf("** Error dmr_cfg: expected %b, got %b", dmr_mask_i, dmr_config_o));
  a_dmr_stop: assert property (@(posedge clk_i) disable iff (!rst_ni) |dmr_config_o &&
      wfi_dmr_o == '0 && !start_boot_o && !dmr_rec_o && !end_sw_routine_i && dmr_error_i[0] &&
      dmr_mask_i == safety_pkg::DMR_MASK_LOW |=> wfi_dmr_o == safety_pkg::DMR_MASK_LOW)
    else record_error($sformatf("** Error dmr_stop: expected 011, got %b", wfi_dmr_o));
  a_dmr_rec: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wfi_dmr_o == safety_pkg::DMR_MASK_LOW && &hart_wfi_i |=>
      interrupt_halt_o == safety_pkg::DMR_MASK_LOW && dmr_rec_o)
    else record_error($sformatf("** Error dmr_rec: expected 011, got %b", interrupt_halt_o));
  a_rec_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      dmr_rec_o && (halt_ack_i & dmr_config_o) != '0 |=> dmr_rec_o)
    else record_error("** Error rec_hold: expected 1, got 0");
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni) en_ext_debug_req_o |->
      interrupt_halt_o == '0 && interrupt_swresync_o == '0)
    else record_error($sformatf("** Error idle: expected 000, got %b", interrupt_halt_o));
  a_delay: assert property (@(posedge clk_i) disable iff (!rst_ni) $fell(delayed_o) |->
      $past(&hart_wfi_i && safe_cfg_i == safety_pkg::CFG_SINGLE))
    else record_error("** Error delayed: expected 1, got 0");

endmodule

bind redundancy_ctrl redundancy_ctrl_sva u_sva (.*, .tmr_in_sync_i(tmr_in_sync));

/* logic/redundancy_ctrl.sv */
// Redundancy controller top
// Boots a three-hart cluster and runs it as a TMR group or a DMR pair
`timescale 1ns/100ps

module redundancy_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  safety_pkg::safe_cfg_t safe_cfg_i,
  input  logic                  start_i,
  input  logic                  end_sw_routine_i,
  input  safety_pkg::hart_vec_t dmr_mask_i,
  input  logic                  tmr_critical_section_i,
  input  logic                  tmr_error_i,
  input  safety_pkg::hart_vec_t dmr_error_i,
  input  safety_pkg::hart_vec_t halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::hart_vec_t hart_intc_ack_i,
  output safety_pkg::hart_vec_t interrupt_halt_o,
  output safety_pkg::hart_vec_t interrupt_swresync_o,
  output safety_pkg::hart_vec_t dmr_config_o,
  output safety_pkg::hart_vec_t wfi_dmr_o,
  output logic                  single_bus_o,
  output logic                  tmr_voter_enable_o,
  output logic                  dmr_comparator_enable_o,
  output logic                  delayed_o,
  output logic                  start_boot_o,
  output logic                  dmr_rec_o,
  output logic                  en_ext_debug_req_o
);
  safety_pkg::mode_e     mode;
  logic                  seq_boot, tmr_error_q, dmr_error_sel;
  safety_pkg::hart_vec_t tmr_idle, tmr_in_sync, tmr_halt, tmr_boot, tmr_bus;
  safety_pkg::hart_vec_t dmr_idle, dmr_delayed, dmr_halt, dmr_boot, dmr_rec;

  mode_sequencer u_seq (
    .clk_i, .rst_ni, .safe_cfg_i, .start_i, .hart_wfi_i,
    .tmr_idle_i(tmr_idle), .dmr_idle_i(dmr_idle),
    .mode_o(mode), .boot_o(seq_boot), .en_ext_debug_req_o
  );

  for (genvar i = 0; i < safety_pkg::N_HARTS; i++) begin : g_tmr_lane
    tmr_lane_fsm u_lane (
      .clk_i, .rst_ni, .mode_i(mode), .start_i, .halt_ack_i(halt_ack_i[i]),
      .hart_wfi_i, .hart_intc_ack_i, .end_sw_routine_i, .tmr_error_i(tmr_error_q),
      .idle_o(tmr_idle[i]), .in_sync_o(tmr_in_sync[i]), .halt_req_o(tmr_halt[i]),
      .boot_o(tmr_boot[i]), .bus_o(tmr_bus[i]), .resync_o(interrupt_swresync_o[i])
    );
  end

  tmr_error_filter u_filter (
    .clk_i, .rst_ni, .tmr_error_i, .tmr_critical_section_i,
    .lane_in_sync_i(tmr_in_sync), .tmr_error_o(tmr_error_q)
  );

  for (genvar i = 0; i < safety_pkg::N_HARTS; i++) begin : g_dmr_lane
    dmr_lane_fsm u_lane (
      .clk_i, .rst_ni, .mode_i(mode), .start_i, .safe_cfg_i, .mask_i(dmr_mask_i[i]),
      .halt_ack_i(halt_ack_i[i]), .hart_wfi_i, .end_sw_routine_i,
      .dmr_error_i(dmr_error_sel), .idle_o(dmr_idle[i]), .active_o(dmr_config_o[i]),
      .delayed_o(dmr_delayed[i]), .halt_req_o(dmr_halt[i]), .boot_o(dmr_boot[i]),
      .rec_o(dmr_rec[i]), .wfi_dmr_o(wfi_dmr_o[i])
    );
  end

  lane_merge u_merge (
    .clk_i, .rst_ni, .safe_cfg_i, .dmr_mask_i, .dmr_error_i, .hart_wfi_i,
    .seq_boot_i(seq_boot), .tmr_halt_i(tmr_halt), .tmr_boot_i(tmr_boot),
    .tmr_bus_i(tmr_bus), .dmr_halt_i(dmr_halt), .dmr_boot_i(dmr_boot),
    .dmr_active_i(dmr_config_o), .dmr_delayed_i(dmr_delayed), .dmr_rec_i(dmr_rec),
    .dmr_error_o(dmr_error_sel), .interrupt_halt_o, .single_bus_o, .tmr_voter_enable_o,
    .dmr_comparator_enable_o, .start_boot_o, .dmr_rec_o, .delayed_o
  );

endmodule

/* logic/lane_merge.sv */
// Lane output merge
// DMR error select, delayed-lockstep flag and cluster-level ORing of lanes
`timescale 1ns/100ps

module lane_merge (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  safety_pkg::safe_cfg_t safe_cfg_i,
  input  safety_pkg::hart_vec_t dmr_mask_i,
  input  safety_pkg::hart_vec_t dmr_error_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  logic                  seq_boot_i,
  input  safety_pkg::hart_vec_t tmr_halt_i,
  input  safety_pkg::hart_vec_t tmr_boot_i,
  input  safety_pkg::hart_vec_t tmr_bus_i,
  input  safety_pkg::hart_vec_t dmr_halt_i,
  input  safety_pkg::hart_vec_t dmr_boot_i,
  input  safety_pkg::hart_vec_t dmr_active_i,
  input  safety_pkg::hart_vec_t dmr_delayed_i,
  input  safety_pkg::hart_vec_t dmr_rec_i,
  output logic                  dmr_error_o,
  output safety_pkg::hart_vec_t interrupt_halt_o,
  output logic                  single_bus_o,
  output logic                  tmr_voter_enable_o,
  output logic                  dmr_comparator_enable_o,
  output logic                  start_boot_o,
  output logic                  dmr_rec_o,
  output logic                  delayed_o
);
  logic delay_q;
  logic delay_clr;

  // Comparator error of the active pair
  always_comb begin
    if (dmr_mask_i == safety_pkg::DMR_MASK_LOW) begin
      dmr_error_o = dmr_error_i[0];
    end else if (dmr_mask_i == safety_pkg::DMR_MASK_HIGH) begin
      dmr_error_o = dmr_error_i[1];
    end else begin
      dmr_error_o = dmr_error_i[2];
    end
  end

  // Delayed lockstep stays on until the cluster is parked in single config
  assign delay_clr = &hart_wfi_i && (safe_cfg_i == safety_pkg::CFG_SINGLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q <= 1'b0;
    end else if (delay_clr) begin
      delay_q <= 1'b0;
    end else if (|dmr_delayed_i) begin
      delay_q <= 1'b1;
    end
  end

  assign delayed_o               = delay_q | (|dmr_delayed_i);
  assign interrupt_halt_o        = tmr_halt_i | dmr_halt_i;
  assign single_bus_o            = (|tmr_bus_i) | (|dmr_active_i) | seq_boot_i;
  assign tmr_voter_enable_o      = (|tmr_bus_i) | seq_boot_i;  // Voter also covers boot
  assign dmr_comparator_enable_o = |dmr_active_i;
  assign start_boot_o            = (|tmr_boot_i) | (|dmr_boot_i);
  assign dmr_rec_o               = |dmr_rec_i;

endmodule

/* logic/dmr_lane_fsm.sv */
// DMR lane sequencer for one hart
// Masked start, lockstep run, stop on compare error and halt-based recovery
`timescale 1ns/100ps

module dmr_lane_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  safety_pkg::mode_e     mode_i,
  input  logic                  start_i,
  input  safety_pkg::safe_cfg_t safe_cfg_i,
  input  logic                  mask_i,
  input  logic                  halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  logic                  end_sw_routine_i,
  input  logic                  dmr_error_i,
  output logic                  idle_o,
  output logic                  active_o,
  output logic                  delayed_o,
  output logic                  halt_req_o,
  output logic                  boot_o,
  output logic                  rec_o,
  output logic                  wfi_dmr_o
);
  safety_pkg::dmr_state_e state_q, state_d;
  logic                   running;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= safety_pkg::DMR_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      safety_pkg::DMR_RESET: state_d = safety_pkg::DMR_IDLE;
      safety_pkg::DMR_IDLE: begin
        // Only harts in the pair take part
        if (mode_i == safety_pkg::MODE_DMR && start_i && mask_i) begin
          state_d = safety_pkg::DMR_START;
        end
      end
      safety_pkg::DMR_START: begin
        if (halt_ack_i) state_d = safety_pkg::DMR_BOOT;
      end
      safety_pkg::DMR_BOOT: begin
        if (!halt_ack_i) state_d = safety_pkg::DMR_SYNC;
      end
      safety_pkg::DMR_SYNC: begin
        if (&hart_wfi_i && end_sw_routine_i) begin
          state_d = safety_pkg::DMR_IDLE;
        end else if (dmr_error_i) begin
          state_d = safety_pkg::DMR_STOP;  // Comparator mismatch
        end
      end
      safety_pkg::DMR_STOP: begin
        if (&hart_wfi_i) state_d = safety_pkg::DMR_INTC_RECOVERY;
      end
      // Recovery reuses the halt exchange
      safety_pkg::DMR_INTC_RECOVERY: begin
        if (halt_ack_i) state_d = safety_pkg::DMR_RECOVERY;
      end
      safety_pkg::DMR_RECOVERY: begin
        if (!halt_ack_i) state_d = safety_pkg::DMR_SYNC;
      end
      default: state_d = safety_pkg::DMR_IDLE;
    endcase
  end

  // Everything past idle except the error stop
  assign running = active_o && (state_q != safety_pkg::DMR_STOP);

  assign idle_o     = (state_q == safety_pkg::DMR_IDLE);
  assign active_o   = !(state_q == safety_pkg::DMR_IDLE || state_q == safety_pkg::DMR_RESET);
  assign delayed_o  = running && (safe_cfg_i == safety_pkg::CFG_DMR_DELAYED);
  assign halt_req_o = (state_q == safety_pkg::DMR_START) ||
                      (state_q == safety_pkg::DMR_INTC_RECOVERY);
  assign boot_o     = (state_q == safety_pkg::DMR_START) || (state_q == safety_pkg::DMR_BOOT);
  assign rec_o      = (state_q == safety_pkg::DMR_INTC_RECOVERY) ||
                      (state_q == safety_pkg::DMR_RECOVERY);
  assign wfi_dmr_o  = (state_q == safety_pkg::DMR_STOP);  // Park the pair in wfi

endmodule

/* logic/tmr_error_filter.sv */
// TMR voter error filter
// Inside a critical section only a second error is passed on
`timescale 1ns/100ps

module tmr_error_filter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tmr_error_i,
  input  logic                  tmr_critical_section_i,
  input  safety_pkg::hart_vec_t lane_in_sync_i,
  output logic                  tmr_error_o
);
  logic err_prev_q;
  logic pending_q;  // An error was seen and not yet serviced
  logic err_rise;

  assign err_rise = tmr_error_i & ~err_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_prev_q <= 1'b0;
      pending_q  <= 1'b0;
    end else begin
      err_prev_q <= tmr_error_i;
      if (|lane_in_sync_i && err_rise) begin
        pending_q <= ~pending_q;
      end else if (!(&lane_in_sync_i)) begin
        pending_q <= 1'b0;  // Lanes left sync, resync under way
      end
    end
  end

  assign tmr_error_o = tmr_critical_section_i ? (err_rise & pending_q)
                                              : (tmr_error_i | pending_q);

endmodule

/* logic/tmr_lane_fsm.sv */
// TMR lane sequencer for one hart
// Halt/boot handshake, synchronous run and software resync on voter error
`timescale 1ns/100ps

module tmr_lane_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  safety_pkg::mode_e     mode_i,
  input  logic                  start_i,
  input  logic                  halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::hart_vec_t hart_intc_ack_i,
  input  logic                  end_sw_routine_i,
  input  logic                  tmr_error_i,
  output logic                  idle_o,
  output logic                  in_sync_o,
  output logic                  halt_req_o,
  output logic                  boot_o,
  output logic                  bus_o,
  output logic                  resync_o
);
  safety_pkg::tmr_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= safety_pkg::TMR_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      safety_pkg::TMR_RESET: state_d = safety_pkg::TMR_IDLE;
      safety_pkg::TMR_IDLE: begin
        if (mode_i == safety_pkg::MODE_TMR && start_i) state_d = safety_pkg::TMR_START;
      end
      safety_pkg::TMR_START: begin
        if (halt_ack_i) state_d = safety_pkg::TMR_BOOT;
      end
      safety_pkg::TMR_BOOT: begin
        if (!halt_ack_i) state_d = safety_pkg::TMR_SYNC;  // Hart released from halt
      end
      safety_pkg::TMR_SYNC: begin
        if (&hart_wfi_i && end_sw_routine_i) begin
          state_d = safety_pkg::TMR_IDLE;
        end else if (tmr_error_i) begin
          state_d = safety_pkg::TMR_SYNCINTC;
        end
      end
      // Software resync, all harts must ack then release
      safety_pkg::TMR_SYNCINTC: begin
        if (&hart_intc_ack_i) state_d = safety_pkg::TMR_SWSYNC;
      end
      safety_pkg::TMR_SWSYNC: begin
        if (~|hart_intc_ack_i) state_d = safety_pkg::TMR_SYNC;
      end
      default: state_d = safety_pkg::TMR_IDLE;
    endcase
  end

  // Moore outputs
  assign idle_o     = (state_q == safety_pkg::TMR_IDLE);
  assign in_sync_o  = (state_q == safety_pkg::TMR_SYNC);
  assign halt_req_o = (state_q == safety_pkg::TMR_START);
  assign boot_o     = (state_q == safety_pkg::TMR_START) || (state_q == safety_pkg::TMR_BOOT);
  assign bus_o      = !(state_q == safety_pkg::TMR_IDLE || state_q == safety_pkg::TMR_RESET);
  assign resync_o   = (state_q == safety_pkg::TMR_SYNCINTC) ||
                      (state_q == safety_pkg::TMR_SWSYNC);

endmodule

/* logic/mode_sequencer.sv */
// General mode sequencer
// Steps the cluster through reset, boot and idle, then into TMR or DMR
`timescale 1ns/100ps

module mode_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  safety_pkg::safe_cfg_t safe_cfg_i,
  input  logic                  start_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::hart_vec_t tmr_idle_i,
  input  safety_pkg::hart_vec_t dmr_idle_i,
  output safety_pkg::mode_e     mode_o,
  output logic                  boot_o,
  output logic                  en_ext_debug_req_o
);
  safety_pkg::mode_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= safety_pkg::MODE_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      safety_pkg::MODE_RESET: state_d = safety_pkg::MODE_BOOT;
      safety_pkg::MODE_BOOT: begin
        if (&hart_wfi_i) state_d = safety_pkg::MODE_IDLE;  // Boot code parked
      end
      safety_pkg::MODE_IDLE: begin
        if (start_i) begin
          if (safe_cfg_i == safety_pkg::CFG_TMR) begin
            state_d = safety_pkg::MODE_TMR;
          end else if (safe_cfg_i == safety_pkg::CFG_DMR ||
                       safe_cfg_i == safety_pkg::CFG_DMR_DELAYED) begin
            state_d = safety_pkg::MODE_DMR;
          end
          // Single config stays here
        end
      end
      safety_pkg::MODE_TMR: begin
        if (!start_i && &tmr_idle_i) state_d = safety_pkg::MODE_IDLE;
      end
      safety_pkg::MODE_DMR: begin
        if (!start_i && &dmr_idle_i) state_d = safety_pkg::MODE_IDLE;
      end
      default: state_d = safety_pkg::MODE_IDLE;
    endcase
  end

  assign mode_o             = state_q;
  assign boot_o             = (state_q == safety_pkg::MODE_BOOT);
  assign en_ext_debug_req_o = (state_q == safety_pkg::MODE_IDLE);  // Debug only when parked

endmodule

/* logic/safety_pkg.sv */
// Safety controller shared definitions
// Hart count, configuration and mask codes, FSM state encodings
package safety_pkg;

  // The majority and mask rules assume exactly three harts
  localparam int unsigned N_HARTS = 3;

  typedef logic [N_HARTS-1:0] hart_vec_t;  // One bit per hart
  typedef logic [1:0]         safe_cfg_t;

  // Safety configuration codes
  localparam safe_cfg_t CFG_SINGLE      = 2'b00;
  localparam safe_cfg_t CFG_TMR         = 2'b01;
  localparam safe_cfg_t CFG_DMR         = 2'b10;
  localparam safe_cfg_t CFG_DMR_DELAYED = 2'b11;

  // DMR pairs, any other mask uses hart 2's comparator
  localparam hart_vec_t DMR_MASK_LOW  = 3'b011;
  localparam hart_vec_t DMR_MASK_HIGH = 3'b110;

  typedef enum logic [2:0] {
    MODE_RESET,
    MODE_BOOT,
    MODE_IDLE,
    MODE_TMR,
    MODE_DMR
  } mode_e;

  typedef enum logic [2:0] {
    TMR_RESET, TMR_IDLE, TMR_START, TMR_BOOT,
    TMR_SYNC, TMR_SYNCINTC, TMR_SWSYNC
  } tmr_state_e;

  typedef enum logic [2:0] {
    DMR_RESET, DMR_IDLE, DMR_START, DMR_BOOT,
    DMR_SYNC, DMR_STOP, DMR_INTC_RECOVERY, DMR_RECOVERY
  } dmr_state_e;

endpackage
